// ==== files.f ====
+incdir+rtl
rtl/wh_pkg.sv
rtl/wh_adapter_in.sv
rtl/wh_flit_fifo.sv
rtl/wh_route_demux.sv
rtl/wh_adapter_out.sv
rtl/wh_subsystem_top.sv
tb/wh_props.sv
tb/wh_tb.sv

// ==== rtl/wh_adapter_in.sv ====
// Input adapter that serializes a whole packet into head and body flits.
`timescale 1ns/1ps
`include "wh_defines.svh"

module wh_adapter_in
  import wh_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_n_i,

  input  packet_t packet_i,
  input  logic    v_i,
  output logic    ready_o,

  output link_t   link_o,
  input  logic    link_ready_i
);

  localparam int pad_width_lp = `WH_MAX_FLITS * `WH_FLIT_WIDTH;

  logic [pad_width_lp-1:0] pkt_padded;
  flit_t                   slots_q [`WH_MAX_FLITS];
  logic                    busy_q;
  logic                    ready_q;
  len_t                    len_q;
  len_t                    cnt_q;
  logic                    accept;
  logic                    send;
  logic                    last;

  assign pkt_padded = pad_width_lp'(packet_i);

  assign ready_o = ready_q;
  assign accept  = v_i & ready_q;
  assign send    = busy_q & link_ready_i;
  assign last    = (cnt_q == len_q);

  assign link_o.v             = busy_q;
  assign link_o.data          = slots_q[0];   // Head slot always leads.
  assign link_o.ready_and_rev = 1'b0;         // No reverse traffic.

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q  <= 1'b0;
      ready_q <= 1'b0;
      len_q   <= '0;
      cnt_q   <= '0;
    end else if (accept) begin
      busy_q  <= 1'b1;
      ready_q <= 1'b0;
      len_q   <= packet_i.len;
      cnt_q   <= '0;
    end else if (send) begin
      cnt_q <= len_t'(cnt_q + 1'b1);
      if (last) begin
        busy_q  <= 1'b0;
        ready_q <= 1'b1;  // Next packet one cycle after the last flit.
      end
    end else if (!busy_q) begin
      ready_q <= 1'b1;  // Leaving reset.
    end
  end

  // Parallel load, then shift toward slot 0 once per sent flit.
  always_ff @(posedge clk_i) begin
    if (accept) begin
      for (int i = 0; i < `WH_MAX_FLITS; i++) begin
        slots_q[i] <= pkt_padded[i*`WH_FLIT_WIDTH +: `WH_FLIT_WIDTH];
      end
    end else if (send) begin
      for (int i = 0; i < `WH_MAX_FLITS - 1; i++) begin
        slots_q[i] <= slots_q[i+1];
      end
      slots_q[`WH_MAX_FLITS-1] <= '0;
    end
  end

endmodule

// ==== rtl/wh_adapter_out.sv ====
// Output adapter that collects the flits of one worm and presents the rebuilt packet.
`timescale 1ns/1ps
`include "wh_defines.svh"

module wh_adapter_out
  import wh_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_n_i,

  input  link_t   link_i,
  output logic    link_ready_o,

  output packet_t packet_o,
  output logic    pkt_v_o,
  input  logic    pkt_ready_i
);

  localparam int pad_width_lp = `WH_MAX_FLITS * `WH_FLIT_WIDTH;

  flit_t                   slots_q [`WH_MAX_FLITS];
  logic [pad_width_lp-1:0] flat;
  rx_state_e               state_q;
  flit_idx_t               idx_q;
  len_t                    len_q;
  len_t                    head_len;
  logic                    take;
  logic                    is_head;

  assign link_ready_o = (state_q == RX_COLLECT);
  assign take         = link_i.v & link_ready_o;
  assign is_head      = (idx_q == '0);
  assign head_len     = link_i.data[`WH_CORD_WIDTH +: `WH_LEN_WIDTH];

  for (genvar g = 0; g < `WH_MAX_FLITS; g++) begin : g_flat
    assign flat[g*`WH_FLIT_WIDTH +: `WH_FLIT_WIDTH] = slots_q[g];
  end

  assign packet_o = packet_t'(flat[$bits(packet_t)-1:0]);
  assign pkt_v_o  = (state_q == RX_PRESENT);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= RX_COLLECT;
      idx_q   <= '0;
      len_q   <= '0;
    end else begin
      case (state_q)
        RX_COLLECT: begin
          if (take && is_head) begin
            len_q <= head_len;
            if (head_len == '0) begin
              state_q <= RX_PRESENT;  // Single-flit worm.
            end else begin
              idx_q <= flit_idx_t'(1);
            end
          end else if (take && len_t'(idx_q) == len_q) begin
            state_q <= RX_PRESENT;
            idx_q   <= '0;
          end else if (take) begin
            idx_q <= flit_idx_t'(idx_q + 1'b1);
          end
        end
        RX_PRESENT: begin
          if (pkt_ready_i) begin
            state_q <= RX_COLLECT;
          end
        end
        default: state_q <= RX_COLLECT;
      endcase
    end
  end

  // Head flit clears the unused slots of a short worm.
  always_ff @(posedge clk_i) begin
    if (take && is_head) begin
      for (int i = 1; i < `WH_MAX_FLITS; i++) begin
        slots_q[i] <= '0;
      end
      slots_q[0] <= link_i.data;
    end else if (take) begin
      slots_q[idx_q] <= link_i.data;
    end
  end

endmodule

// ==== rtl/wh_defines.svh ====
// Width and routing constants for the wormhole network slice.
`ifndef WH_DEFINES_SVH
`define WH_DEFINES_SVH

// One link flit.
`define WH_FLIT_WIDTH 16

// Destination coordinate in the head flit.
`define WH_CORD_WIDTH 4

// Body flits that follow the head flit, 0 to 2.
`define WH_LEN_WIDTH 2

// Payload bits, so that a full packet is 48 bits.
`define WH_MAX_PAYLOAD_WIDTH 42

// Flits in the largest packet.
`define WH_MAX_FLITS 3

// Cord that selects output 1.
`define WH_EAST_CORD 1

`endif

// ==== rtl/wh_flit_fifo.sv ====
// Two-entry flit FIFO between the input adapter and the route stage.
`timescale 1ns/1ps
`include "wh_defines.svh"

module wh_flit_fifo
  import wh_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,

  input  link_t in_link_i,
  output logic  in_ready_o,

  output link_t out_link_o,
  input  logic  out_ready_i
);

  localparam logic [1:0] depth_lp = 2'd2;

  flit_t      mem_q [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;
  logic       wr_en;
  logic       rd_en;

  assign in_ready_o = (count_q != depth_lp);
  assign wr_en      = in_link_i.v & in_ready_o;

  assign out_link_o.v             = (count_q != 2'd0);
  assign out_link_o.data          = mem_q[rd_ptr_q];
  assign out_link_o.ready_and_rev = 1'b0;  // Ready travels on out_ready_i.
  assign rd_en                    = out_link_o.v & out_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (rd_en) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      case ({wr_en, rd_en})
        2'b10:   count_q <= count_q + 2'd1;
        2'b01:   count_q <= count_q - 2'd1;
        default: count_q <= count_q;  // Both or neither.
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_q[wr_ptr_q] <= in_link_i.data;
    end
  end

endmodule

// ==== rtl/wh_pkg.sv ====
// Shared vector, packet, link and state types for the wormhole network slice.
`include "wh_defines.svh"

package wh_pkg;

  typedef logic [`WH_FLIT_WIDTH-1:0]        flit_t;
  typedef logic [`WH_CORD_WIDTH-1:0]        cord_t;
  typedef logic [`WH_LEN_WIDTH-1:0]         len_t;
  typedef logic [`WH_MAX_PAYLOAD_WIDTH-1:0] payload_t;
  typedef logic [$clog2(`WH_MAX_FLITS)-1:0] flit_idx_t;  // Slot index within a packet.

  // Cord sits in the low bits, so the head flit carries cord and len.
  typedef struct packed {
    payload_t payload;
    len_t     len;
    cord_t    cord;
  } packet_t;

  typedef struct packed {
    logic  v;
    flit_t data;
    logic  ready_and_rev;
  } link_t;

  typedef enum logic {
    RX_COLLECT,
    RX_PRESENT
  } rx_state_e;

  typedef enum logic {
    ROUTE_IDLE,
    ROUTE_LOCKED
  } route_state_e;

endpackage

// ==== rtl/wh_route_demux.sv ====
// Route stage that locks each worm onto output 0 or output 1 by its head-flit cord.
`timescale 1ns/1ps
`include "wh_defines.svh"

module wh_route_demux
  import wh_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,

  input  link_t in_link_i,
  output logic  in_ready_o,

  output link_t out0_link_o,
  input  logic  out0_ready_i,

  output link_t out1_link_o,
  input  logic  out1_ready_i
);

  route_state_e state_q;
  logic         port_q;
  len_t         remain_q;
  cord_t        head_cord;
  len_t         head_len;
  logic         head_port;
  logic         sel;
  logic         fire;

  assign head_cord = in_link_i.data[`WH_CORD_WIDTH-1:0];
  assign head_len  = in_link_i.data[`WH_CORD_WIDTH +: `WH_LEN_WIDTH];
  assign head_port = (head_cord == cord_t'(`WH_EAST_CORD));

  // Idle decodes the live head flit, locked follows the stored port.
  assign sel = (state_q == ROUTE_IDLE) ? head_port : port_q;

  assign out0_link_o.v             = in_link_i.v & ~sel;
  assign out0_link_o.data          = in_link_i.data;
  assign out0_link_o.ready_and_rev = 1'b0;

  assign out1_link_o.v             = in_link_i.v & sel;
  assign out1_link_o.data          = in_link_i.data;
  assign out1_link_o.ready_and_rev = 1'b0;

  assign in_ready_o = sel ? out1_ready_i : out0_ready_i;
  assign fire       = in_link_i.v & in_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q  <= ROUTE_IDLE;
      port_q   <= 1'b0;
      remain_q <= '0;
    end else begin
      case (state_q)
        ROUTE_IDLE: begin
          if (fire && head_len != '0) begin
            state_q  <= ROUTE_LOCKED;
            port_q   <= head_port;
            remain_q <= head_len;
          end
        end
        ROUTE_LOCKED: begin
          if (fire) begin
            remain_q <= len_t'(remain_q - 1'b1);
            if (remain_q == len_t'(1)) begin
              state_q <= ROUTE_IDLE;  // Tail flit passed.
            end
          end
        end
        default: state_q <= ROUTE_IDLE;
      endcase
    end
  end

endmodule

// ==== rtl/wh_subsystem_top.sv ====
// Wormhole slice chaining input adapter, flit FIFO, route stage and two output adapters.
`timescale 1ns/1ps
`include "wh_defines.svh"

module wh_subsystem_top
  import wh_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_n_i,

  input  packet_t packet_i,
  input  logic    v_i,
  output logic    ready_o,

  output packet_t packet0_o,
  output logic    pkt0_v_o,
  input  logic    pkt0_ready_i,

  output packet_t packet1_o,
  output logic    pkt1_v_o,
  input  logic    pkt1_ready_i
);

  link_t in_link;
  link_t fifo_link;
  link_t route0_link;
  link_t route1_link;
  logic  in_link_ready;
  logic  fifo_link_ready;
  logic  route0_ready;
  logic  route1_ready;

  wh_adapter_in u_adapter_in (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .packet_i     (packet_i),
    .v_i          (v_i),
    .ready_o      (ready_o),
    .link_o       (in_link),
    .link_ready_i (in_link_ready)
  );

  wh_flit_fifo u_fifo (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_link_i   (in_link),
    .in_ready_o  (in_link_ready),
    .out_link_o  (fifo_link),
    .out_ready_i (fifo_link_ready)
  );

  wh_route_demux u_route (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .in_link_i    (fifo_link),
    .in_ready_o   (fifo_link_ready),
    .out0_link_o  (route0_link),
    .out0_ready_i (route0_ready),
    .out1_link_o  (route1_link),
    .out1_ready_i (route1_ready)
  );

  wh_adapter_out u_adapter_out0 (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .link_i       (route0_link),
    .link_ready_o (route0_ready),
    .packet_o     (packet0_o),
    .pkt_v_o      (pkt0_v_o),
    .pkt_ready_i  (pkt0_ready_i)
  );

  wh_adapter_out u_adapter_out1 (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .link_i       (route1_link),
    .link_ready_o (route1_ready),
    .packet_o     (packet1_o),
    .pkt_v_o      (pkt1_v_o),
    .pkt_ready_i  (pkt1_ready_i)
  );

endmodule

// ==== run.sh ====
#!/bin/sh
# Builds the wormhole slice testbench with Verilator, runs it and checks the log.

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert --top-module wh_tb \
  -f files.f -Mdir "$build_dir" -o wh_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Assertion errors do not stop the run, so the testbench reaches its verdict.
"./$build_dir/wh_sim" +verilator+error+limit+1000 > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Verification passed" "$log_file"; then
  exit 0
fi
echo "Pass message not found in $log_file"
exit 1

// ==== tb/wh_props.sv ====
// Handshake and reset assertions bound into the input adapter and the route stage.
`timescale 1ns/1ps
`include "wh_defines.svh"

module wh_props
  import wh_pkg::*;
(
  input logic  clk_i,
  input logic  rst_n_i,
  input link_t link_i,
  input logic  link_ready_i,
  input logic  out0_v_i,
  input logic  out1_v_i,
  input logic  ready_i
);

  int fail_cnt = 0;  // Read by the testbench at the end of the run.

  logic  in_fire;
  cord_t head_cord;
  len_t  head_len;
  logic  worm_open_q;
  logic  worm_port_q;
  len_t  worm_left_q;

  assign in_fire   = link_i.v && link_ready_i;
  assign head_cord = link_i.data[`WH_CORD_WIDTH-1:0];
  assign head_len  = link_i.data[`WH_CORD_WIDTH +: `WH_LEN_WIDTH];

  // Worm in flight as seen on the incoming link, port taken from the head cord.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      worm_open_q <= 1'b0;
      worm_port_q <= 1'b0;
      worm_left_q <= '0;
    end else if (in_fire && !worm_open_q) begin
      worm_open_q <= (head_len != '0);
      worm_port_q <= (head_cord == cord_t'(`WH_EAST_CORD));
      worm_left_q <= head_len;
    end else if (in_fire) begin
      worm_left_q <= len_t'(worm_left_q - 1'b1);
      if (worm_left_q == len_t'(1)) begin
        worm_open_q <= 1'b0;  // Tail flit passed.
      end
    end
  end

  link_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    link_i.v && !link_ready_i |=> link_i.v && $stable(link_i.data))
    else begin
      $error("link flit changed or vanished before it was accepted");
      fail_cnt++;
    end

  // The other output stays quiet for the whole worm.
  worm_lock_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    worm_open_q |-> !(worm_port_q ? out0_v_i : out1_v_i))
    else begin
      $error("route output other than the locked one valid during a worm");
      fail_cnt++;
    end

  // First cycle out of reset still refuses packets.
  ready_reset_a: assert property (@(posedge clk_i) $rose(rst_n_i) |-> !ready_i)
    else begin
      $error("ready high in the first cycle after reset");
      fail_cnt++;
    end

endmodule

bind wh_adapter_in wh_props u_in_props (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .link_i       (link_o),
  .link_ready_i (link_ready_i),
  .out0_v_i     (1'b0),
  .out1_v_i     (1'b0),
  .ready_i      (ready_o)
);

bind wh_route_demux wh_props u_route_props (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .link_i       (in_link_i),
  .link_ready_i (in_ready_o),
  .out0_v_i     (out0_link_o.v),
  .out1_v_i     (out1_link_o.v),
  .ready_i      (1'b0)
);

// ==== tb/wh_tb.sv ====
// Table-driven testbench for the wormhole slice with per-port scoreboards.
`timescale 1ns/1ps
`include "wh_defines.svh"

module wh_tb
  import wh_pkg::*;
();

  localparam int num_entries_lp    = 16;
  localparam int timeout_cycles_lp = num_entries_lp * 60 + 100;

  typedef struct packed {
    cord_t      cord;
    len_t       len;
    payload_t   payload;
    logic [7:0] ready_pat;  // One ready bit per cycle, cycled on both outputs.
  } entry_t;

  logic    clk_i;
  logic    rst_n_i;
  packet_t packet_i;
  logic    v_i;
  logic    ready_o;
  packet_t packet0_o;
  logic    pkt0_v_o;
  logic    pkt0_ready_i;
  packet_t packet1_o;
  logic    pkt1_v_o;
  logic    pkt1_ready_i;

  cord_t cords [num_entries_lp] = '{
    4'd1, 4'd0, 4'd5, 4'd1, 4'd1, 4'd3, 4'd1, 4'd0,
    4'd0, 4'd1, 4'd7, 4'd1, 4'd0, 4'd1, 4'd2, 4'd1};
  len_t lens [num_entries_lp] = '{
    2'd0, 2'd0, 2'd0, 2'd0, 2'd2, 2'd2, 2'd2, 2'd2,
    2'd1, 2'd1, 2'd1, 2'd2, 2'd1, 2'd0, 2'd2, 2'd1};
  logic [num_entries_lp-1:0] stall_mask = 16'hF800;  // Last five see back-pressure.

  entry_t      tbl [num_entries_lp];
  packet_t     exp0_q [$];
  packet_t     exp1_q [$];
  int          sent_cnt [2] = '{0, 0};
  int          rx_cnt [2] = '{0, 0};
  int          err_cnt = 0;
  logic [15:0] lfsr_q;
  logic [7:0]  cur_pat;

  wh_subsystem_top dut0 (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .packet_i     (packet_i),
    .v_i          (v_i),
    .ready_o      (ready_o),
    .packet0_o    (packet0_o),
    .pkt0_v_o     (pkt0_v_o),
    .pkt0_ready_i (pkt0_ready_i),
    .packet1_o    (packet1_o),
    .pkt1_v_o     (pkt1_v_o),
    .pkt1_ready_i (pkt1_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) n = n ^ 16'hB400;  // Taps 16, 14, 13, 11.
    return n;
  endfunction

  task automatic take_bits(input int n, output logic [63:0] bits);
    bits = '0;
    for (int b = 0; b < n; b++) begin
      bits[b] = lfsr_q[0];
      lfsr_q  = lfsr_step(lfsr_q);
    end
  endtask

  task automatic build_table();
    logic [63:0] bits;
    lfsr_q = 16'd42941;
    for (int k = 0; k < num_entries_lp; k++) begin
      tbl[k].cord = cords[k];
      tbl[k].len  = lens[k];
      take_bits(`WH_MAX_PAYLOAD_WIDTH, bits);
      tbl[k].payload = payload_t'(bits);
      if (stall_mask[k]) begin
        take_bits(8, bits);
        tbl[k].ready_pat = bits[7:0] | 8'h01;  // Never a permanent stall.
      end else begin
        tbl[k].ready_pat = 8'hFF;
      end
    end
  endtask

  // Flits past len never travel, so they come back as zero.
  function automatic packet_t expected_packet(input packet_t p);
    logic [`WH_MAX_FLITS*`WH_FLIT_WIDTH-1:0] flat;
    flat = p;
    for (int f = 0; f < `WH_MAX_FLITS; f++) begin
      if (f > int'(p.len)) flat[f*`WH_FLIT_WIDTH +: `WH_FLIT_WIDTH] = '0;
    end
    return packet_t'(flat);
  endfunction

  function automatic int prop_fail_count();
    return dut0.u_adapter_in.u_in_props.fail_cnt + dut0.u_route.u_route_props.fail_cnt;
  endfunction

  task automatic check_port(input int port, input packet_t got);
    packet_t exp;
    logic    have;
    have = (port == 1) ? (exp1_q.size() > 0) : (exp0_q.size() > 0);
    rx_cnt[port]++;
    assert (have) else begin
      $display("Output %0d delivered a packet at %0t that was never sent", port, $time);
      err_cnt++;
    end
    if (have) begin
      if (port == 1) exp = exp1_q.pop_front();
      else exp = exp0_q.pop_front();
      assert (got == exp) else begin
        $display("FAILED at %0t: output %0d packet %h, expected %h", $time, port, got, exp);
        err_cnt++;
      end
    end
  endtask

  task automatic check_idle();
    assert (!ready_o && !pkt0_v_o && !pkt1_v_o) else begin
      $display("FAILED at %0t: ready_o or pkt_v_o active around reset", $time);
      err_cnt++;
    end
  endtask

  initial begin : ready_drive
    logic [2:0] phase;
    phase        = '0;
    pkt0_ready_i = 1'b0;
    pkt1_ready_i = 1'b0;
    wait (rst_n_i === 1'b1);
    forever begin
      @(posedge clk_i);
      pkt0_ready_i <= cur_pat[phase];
      pkt1_ready_i <= cur_pat[phase + 3'd3];  // Offset so the ports stall apart.
      phase = phase + 3'd1;
    end
  end

  initial begin : output_check
    forever begin
      @(negedge clk_i);
      if (rst_n_i && pkt0_v_o && pkt0_ready_i) check_port(0, packet0_o);
      if (rst_n_i && pkt1_v_o && pkt1_ready_i) check_port(1, packet1_o);
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < timeout_cycles_lp) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", timeout_cycles_lp);
    $display("Errors: %0d data, %0d assertion, 1 timeout", err_cnt, prop_fail_count());
    $display("Verification failed");
    $finish;
  end

  initial begin : stimulus
    packet_t pkt;
    logic    port;
    rst_n_i  = 1'b0;
    v_i      = 1'b0;
    packet_i = '0;
    cur_pat  = 8'hFF;
    build_table();
    for (int c = 0; c < 3; c++) begin
      @(posedge clk_i);
      if (c == 2) rst_n_i <= 1'b1;
      @(negedge clk_i);
      check_idle();
    end
    @(negedge clk_i);
    assert (ready_o) else begin
      $display("FAILED at %0t: ready_o did not rise after reset", $time);
      err_cnt++;
    end
    @(posedge clk_i);
    for (int i = 0; i < num_entries_lp; i++) begin
      pkt.cord    = tbl[i].cord;
      pkt.len     = tbl[i].len;
      pkt.payload = tbl[i].payload;
      packet_i <= pkt;
      v_i      <= 1'b1;
      cur_pat  <= tbl[i].ready_pat;
      port = (pkt.cord == cord_t'(`WH_EAST_CORD));
      if (port) exp1_q.push_back(expected_packet(pkt));
      else exp0_q.push_back(expected_packet(pkt));
      sent_cnt[port]++;
      @(negedge clk_i);
      while (!ready_o) @(negedge clk_i);
      @(posedge clk_i);  // Transfer edge.
    end
    v_i     <= 1'b0;
    cur_pat <= 8'hFF;
    while (rx_cnt[0] < sent_cnt[0] || rx_cnt[1] < sent_cnt[1]) @(negedge clk_i);
    repeat (20) @(negedge clk_i);  // Room for a duplicate to show up.
    for (int p = 0; p < 2; p++) begin
      assert (rx_cnt[p] == sent_cnt[p]) else begin
        $display("Output %0d delivered %0d packets but %0d were sent", p, rx_cnt[p],
                 sent_cnt[p]);
        err_cnt++;
      end
    end
    $display("Errors: %0d data, %0d assertion, 0 timeout", err_cnt, prop_fail_count());
    if (err_cnt == 0 && prop_fail_count() == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
